/* logic/spi_host_bit_cntr.sv */
// SPI host bit and byte counters
`timescale 1ns/1ps

module spi_host_bit_cntr (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          fsm_en_i,
  input  logic                          accept_i,
  input  spi_host_pkg::spi_state_e      state_q_i,
  input  spi_host_pkg::spi_state_e      state_d_i,
  input  logic [spi_host_pkg::LenW-1:0] len_i,
  input  logic                          wr_en_d_i,
  input  logic                          rd_en_d_i,
  input  logic                          rd_en_q_i,
  output logic                          last_bit_o,
  output logic                          last_byte_o,
  output logic                          wr_en_o,
  output logic                          rd_en_o,
  output logic                          shift_en_o,
  output logic                          sample_en_o,
  output logic                          last_write_o,
  output logic                          last_read_o
);
  import spi_host_pkg::*;

  logic               state_changing, byte_starting, bit_shifting, byte_ending;
  logic [BitCntW-1:0] bit_cntr_q, bit_cntr_d, start_bit;
  logic [LenW-1:0]    byte_cntr_q, byte_cntr_d;
  logic               sample_en_q;

  assign state_changing = (state_q_i != state_d_i);
  assign byte_starting  = state_changing &&
                          ((state_d_i == WaitLead) ||
                           (state_d_i == InternalClkLow && bit_cntr_q == '0));
  assign bit_shifting   = state_changing &&
                          (state_d_i == InternalClkLow && bit_cntr_q != '0);
  assign byte_ending    = state_changing &&
                          (state_q_i == InternalClkHigh && bit_cntr_q == '0);

  // Clock-only segments keep the bit counter at zero so every pulse ends a "byte"
  assign start_bit = (wr_en_d_i || rd_en_d_i) ? BitCntW'(7) : '0;

  assign bit_cntr_d = !fsm_en_i     ? bit_cntr_q :
                      byte_starting ? start_bit :
                      bit_shifting  ? bit_cntr_q - 1'b1 :
                      bit_cntr_q;

  // A new length takes priority over the end of the previous segment's last byte
  assign byte_cntr_d = !fsm_en_i   ? byte_cntr_q :
                       accept_i    ? len_i :
                       byte_ending ? byte_cntr_q - 1'b1 :
                       byte_cntr_q;

  assign last_bit_o  = (bit_cntr_q == '0);
  assign last_byte_o = (byte_cntr_q == '0);

  assign wr_en_o      = byte_starting && wr_en_d_i;
  assign rd_en_o      = byte_ending && rd_en_q_i;
  assign shift_en_o   = bit_shifting;
  assign last_write_o = wr_en_o && (byte_cntr_d == '0);
  assign last_read_o  = rd_en_o && (byte_cntr_q == '0);

  // Sampling happens on the step after the data was put on the line
  assign sample_en_o = sample_en_q && fsm_en_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cntr_q  <= '0;
      byte_cntr_q <= '0;
      sample_en_q <= 1'b0;
    end else begin
      bit_cntr_q  <= bit_cntr_d;
      byte_cntr_q <= byte_cntr_d;
      if (fsm_en_i) begin
        sample_en_q <= byte_starting || bit_shifting;
      end
    end
  end

endmodule

/* logic/spi_host_cmd_regs.sv */
// SPI host command registers
`timescale 1ns/1ps

module spi_host_cmd_regs #(
  parameter int NumCS = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     accept_i,
  input  logic [spi_host_pkg::cs_w(NumCS)-1:0]     cmd_csid_i,
  input  logic                                     cmd_cpol_i,
  input  logic [spi_host_pkg::ClkDivW-1:0]         cmd_clkdiv_i,
  input  logic [spi_host_pkg::WaitW-1:0]           cmd_csnlead_i,
  input  logic [spi_host_pkg::WaitW-1:0]           cmd_csntrail_i,
  input  logic [spi_host_pkg::WaitW-1:0]           cmd_csnidle_i,
  input  logic [spi_host_pkg::LenW-1:0]            cmd_len_i,
  input  logic                                     cmd_csaat_i,
  input  logic                                     cmd_wr_en_i,
  input  logic                                     cmd_rd_en_i,
  output logic [spi_host_pkg::cs_w(NumCS)-1:0]     csid_o,
  output logic                                     cpol_o,
  output logic [spi_host_pkg::ClkDivW-1:0]         clkdiv_o,
  output logic [spi_host_pkg::WaitW-1:0]           csnlead_o,
  output logic [spi_host_pkg::WaitW-1:0]           csntrail_o,
  output logic [spi_host_pkg::WaitW-1:0]           csnidle_o,
  output logic [spi_host_pkg::LenW-1:0]            len_o,
  output logic                                     csaat_q_o,
  output logic                                     rd_en_q_o,
  output logic                                     wr_en_d_o,
  output logic                                     rd_en_d_o,
  output logic [spi_host_pkg::cs_w(NumCS)-1:0]     csid_q_o,
  output logic                                     config_changed_o
);
  import spi_host_pkg::*;

  localparam int CsW = cs_w(NumCS);

  logic [CsW-1:0]     csid_q;
  logic               cpol_q, csaat_q, wr_en_q, rd_en_q;
  logic [ClkDivW-1:0] clkdiv_q;
  logic [WaitW-1:0]   csnlead_q, csntrail_q, csnidle_q;
  logic [LenW-1:0]    len_q;

  // Any timing difference for the next device forces a CSB switch period
  assign config_changed_o = (cmd_cpol_i     != cpol_q)     ||
                            (cmd_clkdiv_i   != clkdiv_q)   ||
                            (cmd_csnlead_i  != csnlead_q)  ||
                            (cmd_csntrail_i != csntrail_q) ||
                            (cmd_csnidle_i  != csnidle_q);

  // In the accept cycle the incoming segment is already the current one
  assign csid_o     = accept_i ? cmd_csid_i     : csid_q;
  assign cpol_o     = accept_i ? cmd_cpol_i     : cpol_q;
  assign clkdiv_o   = accept_i ? cmd_clkdiv_i   : clkdiv_q;
  assign csnlead_o  = accept_i ? cmd_csnlead_i  : csnlead_q;
  assign csntrail_o = accept_i ? cmd_csntrail_i : csntrail_q;
  assign csnidle_o  = accept_i ? cmd_csnidle_i  : csnidle_q;
  assign len_o      = accept_i ? cmd_len_i      : len_q;
  assign wr_en_d_o  = accept_i ? cmd_wr_en_i    : wr_en_q;
  assign rd_en_d_o  = accept_i ? cmd_rd_en_i    : rd_en_q;

  assign csid_q_o  = csid_q;
  assign csaat_q_o = csaat_q;
  assign rd_en_q_o = rd_en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csid_q     <= '0;
      cpol_q     <= 1'b0;
      clkdiv_q   <= '0;
      csnlead_q  <= '0;
      csntrail_q <= '0;
      csnidle_q  <= '0;
      len_q      <= '0;
      csaat_q    <= 1'b0;
      wr_en_q    <= 1'b0;
      rd_en_q    <= 1'b0;
    end else if (accept_i) begin
      csid_q     <= cmd_csid_i;
      cpol_q     <= cmd_cpol_i;
      clkdiv_q   <= cmd_clkdiv_i;
      csnlead_q  <= cmd_csnlead_i;
      csntrail_q <= cmd_csntrail_i;
      csnidle_q  <= cmd_csnidle_i;
      len_q      <= cmd_len_i;
      csaat_q    <= cmd_csaat_i;
      wr_en_q    <= cmd_wr_en_i;
      rd_en_q    <= cmd_rd_en_i;
    end
  end

endmodule

/* logic/spi_host_core.sv */
// SPI host sequencer top level
`timescale 1ns/1ps

module spi_host_core #(
  parameter int NumCS = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 en_i,
  input  logic                                 command_valid_i,
  input  logic [spi_host_pkg::cs_w(NumCS)-1:0] cmd_csid_i,
  input  logic                                 cmd_cpol_i,
  input  logic [spi_host_pkg::ClkDivW-1:0]     cmd_clkdiv_i,
  input  logic [spi_host_pkg::WaitW-1:0]       cmd_csnlead_i,
  input  logic [spi_host_pkg::WaitW-1:0]       cmd_csntrail_i,
  input  logic [spi_host_pkg::WaitW-1:0]       cmd_csnidle_i,
  input  logic [spi_host_pkg::LenW-1:0]        cmd_len_i,
  input  logic                                 cmd_csaat_i,
  input  logic                                 cmd_wr_en_i,
  input  logic                                 cmd_rd_en_i,
  output logic                                 command_ready_o,
  output logic                                 sck_o,
  output logic [NumCS-1:0]                     csb_o,
  output logic                                 wr_en_o,
  output logic                                 rd_en_o,
  output logic                                 shift_en_o,
  output logic                                 sample_en_o,
  output logic                                 last_write_o,
  output logic                                 last_read_o,
  output logic                                 active_o
);
  import spi_host_pkg::*;

  localparam int CsW = cs_w(NumCS);

  logic [CsW-1:0]     csid, csid_q;
  logic               cpol, csaat_q, rd_en_q, wr_en_d, rd_en_d, config_changed;
  logic [ClkDivW-1:0] clkdiv;
  logic [WaitW-1:0]   csnlead, csntrail, csnidle;
  logic [LenW-1:0]    len;
  logic               accept, fsm_en, last_bit, last_byte;
  spi_state_e         state_q, state_d;

  spi_host_cmd_regs #(.NumCS(NumCS)) i_cmd_regs (
    .clk_i, .rst_ni,
    .accept_i         (accept),
    .cmd_csid_i, .cmd_cpol_i, .cmd_clkdiv_i,
    .cmd_csnlead_i, .cmd_csntrail_i, .cmd_csnidle_i,
    .cmd_len_i, .cmd_csaat_i, .cmd_wr_en_i, .cmd_rd_en_i,
    .csid_o           (csid),
    .cpol_o           (cpol),
    .clkdiv_o         (clkdiv),
    .csnlead_o        (csnlead),
    .csntrail_o       (csntrail),
    .csnidle_o        (csnidle),
    .len_o            (len),
    .csaat_q_o        (csaat_q),
    .rd_en_q_o        (rd_en_q),
    .wr_en_d_o        (wr_en_d),
    .rd_en_d_o        (rd_en_d),
    .csid_q_o         (csid_q),
    .config_changed_o (config_changed)
  );

  spi_host_seq #(.NumCS(NumCS)) i_seq (
    .clk_i, .rst_ni, .en_i, .command_valid_i, .cmd_csid_i,
    .csid_q_i         (csid_q),
    .config_changed_i (config_changed),
    .clkdiv_i         (clkdiv),
    .csnlead_i        (csnlead),
    .csntrail_i       (csntrail),
    .csnidle_i        (csnidle),
    .csaat_q_i        (csaat_q),
    .last_bit_i       (last_bit),
    .last_byte_i      (last_byte),
    .command_ready_o,
    .accept_o         (accept),
    .fsm_en_o         (fsm_en),
    .state_q_o        (state_q),
    .state_d_o        (state_d),
    .active_o
  );

  spi_host_bit_cntr i_bit_cntr (
    .clk_i, .rst_ni,
    .fsm_en_i    (fsm_en),
    .accept_i    (accept),
    .state_q_i   (state_q),
    .state_d_i   (state_d),
    .len_i       (len),
    .wr_en_d_i   (wr_en_d),
    .rd_en_d_i   (rd_en_d),
    .rd_en_q_i   (rd_en_q),
    .last_bit_o  (last_bit),
    .last_byte_o (last_byte),
    .wr_en_o, .rd_en_o, .shift_en_o, .sample_en_o, .last_write_o, .last_read_o
  );

  spi_host_pins #(.NumCS(NumCS)) i_pins (
    .clk_i, .rst_ni,
    .state_d_i (state_d),
    .cpol_i    (cpol),
    .csid_i    (csid),
    .sck_o, .csb_o
  );

endmodule

/* logic/spi_host_pins.sv */
// SPI host clock and chip select pins
`timescale 1ns/1ps

module spi_host_pins #(
  parameter int NumCS = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  spi_host_pkg::spi_state_e             state_d_i,
  input  logic                                 cpol_i,
  input  logic [spi_host_pkg::cs_w(NumCS)-1:0] csid_i,
  output logic                                 sck_o,
  output logic [NumCS-1:0]                     csb_o
);
  import spi_host_pkg::*;

  localparam int CsW = cs_w(NumCS);

  logic sck_d, csb_single_d;

  // CSB is asserted from the lead wait through the trail wait
  always_comb begin
    case (state_d_i)
      WaitLead, InternalClkLow, InternalClkHigh, IdleCSBActive, WaitTrail: begin
        csb_single_d = 1'b0;
      end
      default: csb_single_d = 1'b1;
    endcase
  end

  assign sck_d = cpol_i ^ (state_d_i == InternalClkHigh);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sck_o <= SckRstVal;
    end else begin
      sck_o <= sck_d;
    end
  end

  for (genvar ii = 0; ii < NumCS; ii++) begin : gen_csb
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        csb_o[ii] <= CsbRstVal;
      end else begin
        csb_o[ii] <= (csid_i != CsW'(ii)) ? 1'b1 : csb_single_d;
      end
    end
  end

endmodule

/* logic/spi_host_pkg.sv */
// SPI host shared definitions
package spi_host_pkg;

  // Field widths of a command segment
  localparam int ClkDivW = 16;
  localparam int WaitW   = 4;
  localparam int LenW    = 24;
  localparam int BitCntW = 3;

  // Pin levels while in reset
  localparam logic SckRstVal = 1'b0;
  localparam logic CsbRstVal = 1'b1;

  // Sequencer states
  typedef enum logic [2:0] {
    Idle,
    WaitLead,
    InternalClkLow,
    InternalClkHigh,
    WaitTrail,
    WaitIdle,
    CSBSwitch,
    IdleCSBActive
  } spi_state_e;

  // Width of a chip select number, never less than one bit
  function automatic int cs_w(int num_cs);
    int w;
    w = $clog2(num_cs);
    return (w > 1) ? w : 1;
  endfunction

endpackage

/* logic/spi_host_seq.sv */
// SPI host sequencer FSM
`timescale 1ns/1ps

module spi_host_seq #(
  parameter int NumCS = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 en_i,
  input  logic                                 command_valid_i,
  input  logic [spi_host_pkg::cs_w(NumCS)-1:0] cmd_csid_i,
  input  logic [spi_host_pkg::cs_w(NumCS)-1:0] csid_q_i,
  input  logic                                 config_changed_i,
  input  logic [spi_host_pkg::ClkDivW-1:0]     clkdiv_i,
  input  logic [spi_host_pkg::WaitW-1:0]       csnlead_i,
  input  logic [spi_host_pkg::WaitW-1:0]       csntrail_i,
  input  logic [spi_host_pkg::WaitW-1:0]       csnidle_i,
  input  logic                                 csaat_q_i,
  input  logic                                 last_bit_i,
  input  logic                                 last_byte_i,
  output logic                                 command_ready_o,
  output logic                                 accept_o,
  output logic                                 fsm_en_o,
  output spi_host_pkg::spi_state_e             state_q_o,
  output spi_host_pkg::spi_state_e             state_d_o,
  output logic                                 active_o
);
  import spi_host_pkg::*;

  spi_state_e         state_q, state_d, after_idle, after_hold;
  logic [ClkDivW-1:0] clk_cntr_q, clk_cntr_d;
  logic [WaitW-1:0]   wait_cntr_q, wait_cntr_d;
  logic               is_idle, fsm_en, ready, ready_hold;

  assign is_idle         = (state_q == Idle) || (state_q == IdleCSBActive);
  assign fsm_en          = en_i && (clk_cntr_q == '0);
  assign command_ready_o = ready;
  assign accept_o        = command_valid_i && ready;
  assign fsm_en_o        = fsm_en;
  assign state_q_o       = state_q;
  assign state_d_o       = state_d;
  assign active_o        = ~is_idle;

  // Each state spans clkdiv+1 cycles
  assign clk_cntr_d = !en_i                          ? clk_cntr_q :
                      is_idle                        ? '0 :
                      (accept_o || clk_cntr_q == '0) ? clkdiv_i :
                      clk_cntr_q - 1'b1;

  always_comb begin
    after_idle = Idle;
    if (command_valid_i) begin
      after_idle = config_changed_i ? CSBSwitch : WaitLead;
    end
  end

  // While CSB is held, a request for another device is taken only after WaitIdle
  always_comb begin
    after_hold = IdleCSBActive;
    ready_hold = 1'b1;
    if (command_valid_i) begin
      if (cmd_csid_i != csid_q_i) begin
        after_hold = WaitTrail;
        ready_hold = 1'b0;
      end else begin
        after_hold = InternalClkLow;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    ready   = 1'b0;
    if (fsm_en) begin
      case (state_q)
        Idle: begin
          ready   = 1'b1;
          state_d = after_idle;
        end
        WaitLead: begin
          if (wait_cntr_q == '0) state_d = InternalClkHigh;
        end
        InternalClkLow: state_d = InternalClkHigh;
        InternalClkHigh: begin
          if (!last_bit_i || !last_byte_i) begin
            state_d = InternalClkLow;
          end else if (!csaat_q_i) begin
            state_d = WaitTrail;
          end else begin
            state_d = after_hold;
            ready   = ready_hold;
          end
        end
        WaitTrail: begin
          if (wait_cntr_q == '0) state_d = WaitIdle;
        end
        WaitIdle: begin
          if (wait_cntr_q == '0) begin
            ready   = 1'b1;
            state_d = after_idle;
          end
        end
        CSBSwitch: begin
          if (wait_cntr_q == '0) state_d = WaitLead;
        end
        IdleCSBActive: begin
          state_d = after_hold;
          ready   = ready_hold;
        end
        default: state_d = Idle;
      endcase
    end
  end

  // Wait counts are loaded on entry and count down once per step
  always_comb begin
    wait_cntr_d = wait_cntr_q;
    if (fsm_en) begin
      if (state_d != state_q) begin
        case (state_d)
          WaitLead:             wait_cntr_d = csnlead_i;
          WaitTrail:            wait_cntr_d = csntrail_i;
          WaitIdle, CSBSwitch:  wait_cntr_d = csnidle_i;
          default:              wait_cntr_d = '0;
        endcase
      end else if (wait_cntr_q != '0) begin
        wait_cntr_d = wait_cntr_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      clk_cntr_q  <= '0;
      wait_cntr_q <= '0;
    end else begin
      state_q     <= state_d;
      clk_cntr_q  <= clk_cntr_d;
      wait_cntr_q <= wait_cntr_d;
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SPI host testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_spi_host_core \
  -f spi_host_core.f \
  -o sim_spi_host_core

./obj_dir/sim_spi_host_core 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

/* spi_host_core.f */
logic/spi_host_pkg.sv
logic/spi_host_cmd_regs.sv
logic/spi_host_seq.sv
logic/spi_host_bit_cntr.sv
logic/spi_host_pins.sv
logic/spi_host_core.sv
verification/spi_host_core_chk.sv
verification/tb_spi_host_core.sv

/* verification/spi_host_core_chk.sv */
// SPI host port assertions
`timescale 1ns/1ps

module spi_host_core_chk #(
  parameter int NumCS = 4
) (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             command_valid_i,
  input logic             command_ready_o,
  input logic             active_o,
  input logic [NumCS-1:0] csb_o,
  input logic             wr_en_o,
  input logic             rd_en_o,
  input logic             shift_en_o,
  input logic             sample_en_o
);

  // Only the command taken from an idle state may start a byte while inactive
  property quiet_when_inactive;
    @(posedge clk_i) disable iff (!rst_ni)
      (!active_o && !(command_valid_i && command_ready_o)) |->
        !(wr_en_o || rd_en_o || shift_en_o || sample_en_o);
  endproperty

  // A selected device is released before another one is selected
  property one_device_selected;
    @(posedge clk_i) disable iff (!rst_ni)
      (csb_o != '1) |->
        ($countones(~csb_o) == 1) && (($past(csb_o) == '1) || (csb_o == $past(csb_o)));
  endproperty

  // Reading and shifting happen in a clock phase, so a device is selected
  property selected_while_shifting;
    @(posedge clk_i) disable iff (!rst_ni)
      (rd_en_o || shift_en_o) |-> (csb_o != '1);
  endproperty

  assert property (quiet_when_inactive) else $error("Strobe while the sequencer is inactive");
  assert property (one_device_selected)
    else $error("Chip select moved to another device without a release");
  assert property (selected_while_shifting) else $error("Read or shift with no device selected");

endmodule

bind spi_host_core spi_host_core_chk #(.NumCS(NumCS)) i_chk (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .command_valid_i (command_valid_i),
  .command_ready_o (command_ready_o),
  .active_o        (active_o),
  .csb_o           (csb_o),
  .wr_en_o         (wr_en_o),
  .rd_en_o         (rd_en_o),
  .shift_en_o      (shift_en_o),
  .sample_en_o     (sample_en_o)
);

/* verification/tb_spi_host_core.sv */
// SPI host sequencer testbench
`timescale 1ns/1ps

module tb_spi_host_core;
  localparam int          NumCS       = 4;
  localparam int          ClkPeriod   = 20;
  localparam int          NumSegments = 40;
  localparam int          WaitLimit   = 5000;
  localparam logic [31:0] Seed        = 32'h60d9;

  logic             clk_i, rst_ni, en_i, command_valid_i;
  logic [1:0]       cmd_csid_i;
  logic             cmd_cpol_i, cmd_csaat_i, cmd_wr_en_i, cmd_rd_en_i;
  logic [15:0]      cmd_clkdiv_i;
  logic [3:0]       cmd_csnlead_i, cmd_csntrail_i, cmd_csnidle_i;
  logic [23:0]      cmd_len_i;
  logic             command_ready_o, sck_o, wr_en_o, rd_en_o, shift_en_o, sample_en_o;
  logic             last_write_o, last_read_o, active_o;
  logic [NumCS-1:0] csb_o;

  logic [31:0] lfsr;
  int          errors, timeouts;
  // Expected segment and what the monitor saw of it
  int          exp_len, exp_clkdiv, exp_csid;
  logic        exp_cpol, exp_wr, exp_rd, exp_csaat;
  logic        counting, accepted, seen_low, prev_sck;
  int          n_wr, n_rd, n_shift, n_sample, n_lastw, n_lastr, lastw_at, lastr_at;
  int          n_sck, high_run, csb_high;

  spi_host_core #(.NumCS(NumCS)) i_spi_host_core (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  task automatic check_equal(int got, int exp, string what);
    if (got != exp) begin
      errors++;
      $display("FAIL %0t: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  always @(negedge clk_i) begin
    if (counting) begin
      if (wr_en_o) n_wr++;
      if (rd_en_o) n_rd++;
      if (shift_en_o) n_shift++;
      if (sample_en_o) n_sample++;
      if (last_write_o) begin
        n_lastw++;
        lastw_at = n_wr;
      end
      if (last_read_o) begin
        n_lastr++;
        lastr_at = n_rd;
      end
      if (accepted) begin
        if (sck_o != exp_cpol) begin
          if (prev_sck == exp_cpol) n_sck++;
          high_run++;
        end else if (high_run > 0) begin
          check_equal(high_run, exp_clkdiv + 1, "sck active phase length");
          high_run = 0;
        end
        check_equal(int'(&(csb_o | (NumCS'(1) << exp_csid))), 1, "csb of other devices");
      end
      // A line held over from the previous segment is low from the first cycle on
      if (!csb_o[exp_csid]) seen_low = 1'b1;
      else if (!seen_low) csb_high++;
      if (command_valid_i && command_ready_o) accepted = 1'b1;
    end
    prev_sck = sck_o;
  end

  task automatic run_segment(output logic ok);
    int   cycles, bytes, prev_csid;
    logic cont;
    prev_csid = exp_csid;
    cont      = exp_csaat;
    // Reuse the device half the time so held chip selects get exercised
    if (take_bits(1) == 32'd0) exp_csid = int'(take_bits(2));
    cont       = cont && (exp_csid == prev_csid);
    exp_len    = int'(take_bits(2));
    exp_clkdiv = int'(take_bits(2));
    exp_cpol   = take_bits(1) != 32'd0;
    exp_csaat  = take_bits(1) != 32'd0;
    exp_wr     = take_bits(1) != 32'd0;
    exp_rd     = take_bits(1) != 32'd0;
    {n_wr, n_rd, n_shift, n_sample, n_lastw, n_lastr} = '0;
    {lastw_at, lastr_at, n_sck, high_run, csb_high} = '0;
    accepted = 1'b0;
    seen_low = 1'b0;
    cmd_csid_i      = 2'(exp_csid);
    cmd_cpol_i      = exp_cpol;
    cmd_clkdiv_i    = 16'(exp_clkdiv);
    cmd_csnlead_i   = 4'(take_bits(2));
    cmd_csntrail_i  = 4'(take_bits(2));
    cmd_csnidle_i   = 4'(take_bits(2));
    cmd_len_i       = 24'(exp_len);
    cmd_csaat_i     = exp_csaat;
    cmd_wr_en_i     = exp_wr;
    cmd_rd_en_i     = exp_rd;
    command_valid_i = 1'b1;
    counting        = 1'b1;
    ok              = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!command_ready_o && cycles < WaitLimit);
    if (!command_ready_o) begin
      $display("Timeout: command was never accepted at %0t", $time);
      timeouts++;
      return;
    end
    @(posedge clk_i);
    #2;
    command_valid_i = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (active_o && cycles < WaitLimit);
    if (active_o) begin
      $display("Timeout: segment never finished at %0t", $time);
      timeouts++;
      return;
    end
    @(posedge clk_i);
    #2;
    counting = 1'b0;
    bytes = exp_len + 1;
    check_equal(n_wr, exp_wr ? bytes : 0, "wr_en pulses");
    check_equal(n_rd, exp_rd ? bytes : 0, "rd_en pulses");
    check_equal(n_lastw, int'(exp_wr), "last_write pulses");
    check_equal(n_lastr, int'(exp_rd), "last_read pulses");
    check_equal(lastw_at, exp_wr ? bytes : 0, "last_write position");
    check_equal(lastr_at, exp_rd ? bytes : 0, "last_read position");
    check_equal(n_shift, (exp_wr || exp_rd) ? 7 * bytes : 0, "shift_en pulses");
    check_equal(n_sample, (exp_wr || exp_rd) ? 8 * bytes : bytes, "sample_en pulses");
    check_equal(n_sck, (exp_wr || exp_rd) ? 8 * bytes : bytes, "sck pulses");
    check_equal(int'(csb_high == 0), int'(cont), "csb held from previous segment");
    check_equal(int'(csb_o), exp_csaat ? (15 & ~(1 << exp_csid)) : 15, "csb after segment");
    check_equal(int'(sck_o), int'(exp_cpol), "sck idle level");
    ok = 1'b1;
  endtask

  initial begin
    logic ok;
    int   cycles;
    lfsr = Seed;
    {errors, timeouts, exp_csid} = '0;
    {exp_cpol, exp_wr, exp_rd, exp_csaat, counting, accepted, seen_low, prev_sck} = '0;
    rst_ni = 1'b0;
    en_i   = 1'b1;
    command_valid_i = 1'b0;
    {cmd_csid_i, cmd_cpol_i, cmd_csaat_i, cmd_wr_en_i, cmd_rd_en_i} = '0;
    {cmd_clkdiv_i, cmd_csnlead_i, cmd_csntrail_i, cmd_csnidle_i, cmd_len_i} = '0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_equal(int'(csb_o), 15, "csb after reset");
    check_equal(int'(sck_o), 0, "sck after reset");
    check_equal(int'(active_o), 0, "active after reset");
    check_equal(int'(wr_en_o || rd_en_o || shift_en_o || sample_en_o), 0, "strobes after reset");
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!command_ready_o && cycles < WaitLimit);
    ok = command_ready_o;
    if (!ok) begin
      $display("Timeout: command_ready never rose after reset");
      timeouts++;
    end
    @(posedge clk_i);
    #2;
    for (int i = 0; i < NumSegments && ok; i++) begin
      run_segment(ok);
    end
    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
